// ==== include/exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// data path width, also the pc and immediate width
`define XLEN 32

// global history bits carried with each prediction
`define HISLEN 8

// opaque trap bus, only passed along by this stage
`define TRAP_LEN 4

// gpr index, 32 architectural registers
`define REG_ADDR_W 5

`endif

// ==== hw/exu_isa_pkg.sv ====
`include "exu_macros.svh"

package exu_isa_pkg;

  typedef logic [`XLEN-1:0]       word_t;   // data, pc, immediate
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [`HISLEN-1:0]     hist_t;
  typedef logic [`TRAP_LEN-1:0]   trap_t;
  typedef logic [2:0]             mem_op_t; // load/store size and sign, decoded later

  // instruction class from decode
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_LUI    = 4'd1,
    EXC_AUIPC  = 4'd2,
    EXC_JAL    = 4'd3,
    EXC_JALR   = 4'd4,
    EXC_LOAD   = 4'd5,
    EXC_STORE  = 4'd6,
    EXC_BRANCH = 4'd7,
    EXC_OPIMM  = 4'd8,
    EXC_OPREG  = 4'd9,
    EXC_EBREAK = 4'd10
  } exc_op_e;

  // upper six codes are the branch compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    JT_NONE   = 2'd0,
    JT_JAL    = 2'd1,
    JT_JALR   = 2'd2,
    JT_BRANCH = 2'd3
  } jump_type_e;

endpackage

// ==== hw/exu_pipe_pkg.sv ====
package exu_pipe_pkg;

  // decode -> execute
  typedef struct packed {
    exu_isa_pkg::word_t    pc;
    exu_isa_pkg::word_t    inst;
    exu_isa_pkg::reg_idx_t rd;
    exu_isa_pkg::word_t    rs1_data;
    exu_isa_pkg::word_t    rs2_data;
    exu_isa_pkg::word_t    imm;
    exu_isa_pkg::exc_op_e  exc_op;
    exu_isa_pkg::alu_op_e  alu_op;
    exu_isa_pkg::mem_op_t  mem_op;
    exu_isa_pkg::trap_t    trap;
    logic                  pdt_taken;   // direction guessed at fetch
    logic                  which_pdt;   // which predictor table made the guess
    exu_isa_pkg::hist_t    history;     // history snapshot used for the guess
  } id_ex_t;

  // execute -> memory
  typedef struct packed {
    exu_isa_pkg::word_t    pc;
    exu_isa_pkg::word_t    inst;
    exu_isa_pkg::reg_idx_t rd;
    exu_isa_pkg::word_t    rs2_data;    // store data
    exu_isa_pkg::word_t    alu_result;  // address for ld/st, link for jumps
    exu_isa_pkg::mem_op_t  mem_op;
    exu_isa_pkg::exc_op_e  exc_op;
    exu_isa_pkg::trap_t    trap;
  } ex_mem_t;

  // feedback to the predictor, one per control transfer
  typedef struct packed {
    exu_isa_pkg::word_t      pc;
    logic                    taken;
    logic                    correct;
    exu_isa_pkg::jump_type_e jump_type;
    logic                    which_pdt;
    exu_isa_pkg::hist_t      history;
  } bpu_update_t;

  typedef struct packed {
    exu_isa_pkg::word_t pc;
  } redirect_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`include "exu_macros.svh"

module alu (
  input  exu_isa_pkg::word_t   a_i,
  input  exu_isa_pkg::word_t   b_i,
  input  exu_isa_pkg::alu_op_e op_i,
  output exu_isa_pkg::word_t   result_o,
  output logic                 cmp_o
);

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               eq;
  logic               lt;
  logic               ltu;

  assign shamt = b_i[SHAMT_W-1:0];  // only low bits count, as in rv32i
  assign eq    = (a_i == b_i);
  assign lt    = ($signed(a_i) < $signed(b_i));
  assign ltu   = (a_i < b_i);

  always_comb begin
    cmp_o    = 1'b0;
    result_o = '0;
    case (op_i)
      exu_isa_pkg::ALU_ADD:  result_o = a_i + b_i;
      exu_isa_pkg::ALU_SUB:  result_o = a_i - b_i;
      exu_isa_pkg::ALU_SLL:  result_o = a_i << shamt;
      exu_isa_pkg::ALU_SLT:  result_o = exu_isa_pkg::word_t'(lt);
      exu_isa_pkg::ALU_SLTU: result_o = exu_isa_pkg::word_t'(ltu);
      exu_isa_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      exu_isa_pkg::ALU_SRL:  result_o = a_i >> shamt;
      exu_isa_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      exu_isa_pkg::ALU_OR:   result_o = a_i | b_i;
      exu_isa_pkg::ALU_AND:  result_o = a_i & b_i;
      exu_isa_pkg::ALU_EQ:   cmp_o    = eq;
      exu_isa_pkg::ALU_NE:   cmp_o    = ~eq;
      exu_isa_pkg::ALU_LT:   cmp_o    = lt;
      exu_isa_pkg::ALU_GE:   cmp_o    = ~lt;
      exu_isa_pkg::ALU_LTU:  cmp_o    = ltu;
      exu_isa_pkg::ALU_GEU:  cmp_o    = ~ltu;
      default: begin
        cmp_o    = 1'b0;
        result_o = '0;
      end
    endcase
    // compares also show up on the result bus
    if (op_i >= exu_isa_pkg::ALU_EQ) begin
      result_o = exu_isa_pkg::word_t'(cmp_o);
    end
  end

endmodule

// ==== hw/exu.sv ====
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu (
  input  exu_pipe_pkg::id_ex_t      id_ex_i,
  output exu_pipe_pkg::ex_mem_t     ex_mem_o,
  output logic                      taken_o,
  output logic                      mispredict_o,
  output logic                      branch_o,
  output exu_pipe_pkg::redirect_t   redirect_pc_o,
  output exu_pipe_pkg::bpu_update_t bpu_update_o
);

  exu_isa_pkg::word_t      alu_a;
  exu_isa_pkg::word_t      alu_b;
  exu_isa_pkg::word_t      alu_result;
  exu_isa_pkg::word_t      imm_hi;
  exu_isa_pkg::word_t      target_base;
  exu_isa_pkg::word_t      target_off;
  exu_isa_pkg::jump_type_e jump_type;
  logic                    cmp;
  logic                    is_jal;
  logic                    is_jalr;
  logic                    is_branch;

  assign is_jal    = (id_ex_i.exc_op == exu_isa_pkg::EXC_JAL);
  assign is_jalr   = (id_ex_i.exc_op == exu_isa_pkg::EXC_JALR);
  assign is_branch = (id_ex_i.exc_op == exu_isa_pkg::EXC_BRANCH);

  assign imm_hi = {id_ex_i.imm[`XLEN-1:12], 12'b0};  // u-type immediate

  always_comb begin
    alu_a = '0;
    alu_b = '0;
    case (id_ex_i.exc_op)
      exu_isa_pkg::EXC_OPREG,
      exu_isa_pkg::EXC_BRANCH: begin
        alu_a = id_ex_i.rs1_data;
        alu_b = id_ex_i.rs2_data;
      end
      exu_isa_pkg::EXC_OPIMM,
      exu_isa_pkg::EXC_LOAD,
      exu_isa_pkg::EXC_STORE: begin
        alu_a = id_ex_i.rs1_data;
        alu_b = id_ex_i.imm;
      end
      exu_isa_pkg::EXC_JAL,
      exu_isa_pkg::EXC_JALR: begin
        alu_a = id_ex_i.pc;  // link address pc+4
        alu_b = exu_isa_pkg::word_t'(4);
      end
      exu_isa_pkg::EXC_AUIPC: begin
        alu_a = id_ex_i.pc;
        alu_b = imm_hi;
      end
      exu_isa_pkg::EXC_LUI: begin
        alu_b = imm_hi;  // a stays zero
      end
      default: ;
    endcase
  end

  alu alu_inst (
    .a_i      (alu_a),
    .b_i      (alu_b),
    .op_i     (id_ex_i.alu_op),
    .result_o (alu_result),
    .cmp_o    (cmp)
  );

  assign branch_o     = is_jal | is_jalr | is_branch;
  assign taken_o      = (is_branch & cmp) | is_jal | is_jalr;
  assign mispredict_o = (taken_o != id_ex_i.pdt_taken);

  // wrong taken guess falls back to pc+4, otherwise go to the real target
  always_comb begin
    if (id_ex_i.pdt_taken && !taken_o) begin
      target_base = id_ex_i.pc;
      target_off  = exu_isa_pkg::word_t'(4);
    end else begin
      target_base = is_jalr ? id_ex_i.rs1_data : id_ex_i.pc;
      target_off  = id_ex_i.imm;
    end
  end

  assign redirect_pc_o.pc = target_base + target_off;

  always_comb begin
    if (is_jal)         jump_type = exu_isa_pkg::JT_JAL;
    else if (is_jalr)   jump_type = exu_isa_pkg::JT_JALR;
    else if (is_branch) jump_type = exu_isa_pkg::JT_BRANCH;
    else                jump_type = exu_isa_pkg::JT_NONE;
  end

  assign bpu_update_o.pc        = id_ex_i.pc;
  assign bpu_update_o.taken     = taken_o;
  assign bpu_update_o.correct   = ~mispredict_o;
  assign bpu_update_o.jump_type = jump_type;
  assign bpu_update_o.which_pdt = id_ex_i.which_pdt;  // echoed back for the table update
  assign bpu_update_o.history   = id_ex_i.history;

  assign ex_mem_o.pc         = id_ex_i.pc;
  assign ex_mem_o.inst       = id_ex_i.inst;
  assign ex_mem_o.rd         = id_ex_i.rd;
  assign ex_mem_o.rs2_data   = id_ex_i.rs2_data;
  assign ex_mem_o.alu_result = alu_result;
  assign ex_mem_o.mem_op     = id_ex_i.mem_op;
  assign ex_mem_o.exc_op     = id_ex_i.exc_op;
  assign ex_mem_o.trap       = id_ex_i.trap;  // not interpreted here

endmodule

// ==== hw/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  in_valid_i,
  input  exu_pipe_pkg::ex_mem_t in_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output exu_pipe_pkg::ex_mem_t out_o,
  input  logic                  out_ready_i
);

  logic load;

  // free slot, or the current entry drains this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;  // drops when drained with nothing behind it
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_o <= in_i;
    end
  end

endmodule

// ==== hw/bpu_stats.sv ====
`timescale 1ns/1ps

module bpu_stats (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fire_i,
  input  logic               branch_i,
  input  logic               mispredict_i,
  output exu_isa_pkg::word_t branch_count_o,
  output exu_isa_pkg::word_t mispredict_count_o
);

  logic resolved;

  assign resolved = fire_i & branch_i;  // jal, jalr and conditional branches

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      branch_count_o     <= '0;
      mispredict_count_o <= '0;
    end else if (resolved) begin
      branch_count_o <= branch_count_o + 1'b1;  // free running, wraps
      if (mispredict_i) begin
        mispredict_count_o <= mispredict_count_o + 1'b1;
      end
    end
  end

endmodule

// ==== hw/exu_stage.sv ====
`timescale 1ns/1ps

module exu_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      id_ex_valid_i,
  input  exu_pipe_pkg::id_ex_t      id_ex_i,
  output logic                      id_ex_ready_o,
  output logic                      ex_mem_valid_o,
  output exu_pipe_pkg::ex_mem_t     ex_mem_o,
  input  logic                      ex_mem_ready_i,
  output logic                      redirect_valid_o,
  output exu_pipe_pkg::redirect_t   redirect_pc_o,
  output logic                      bpu_update_valid_o,
  output exu_pipe_pkg::bpu_update_t bpu_update_o,
  output exu_isa_pkg::word_t        branch_count_o,
  output exu_isa_pkg::word_t        mispredict_count_o
);

  exu_pipe_pkg::ex_mem_t ex_result;
  logic                  fire;
  logic                  mispredict;
  logic                  branch;

  assign fire = id_ex_valid_i & id_ex_ready_o;

  exu exu_inst (
    .id_ex_i       (id_ex_i),
    .ex_mem_o      (ex_result),
    .taken_o       (),  // already part of bpu_update_o
    .mispredict_o  (mispredict),
    .branch_o      (branch),
    .redirect_pc_o (redirect_pc_o),
    .bpu_update_o  (bpu_update_o)
  );

  // only meaningful in the transfer cycle
  assign redirect_valid_o   = fire & mispredict;
  assign bpu_update_valid_o = fire & branch;

  ex_mem_reg ex_mem_reg_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (id_ex_valid_i),
    .in_i        (ex_result),
    .in_ready_o  (id_ex_ready_o),
    .out_valid_o (ex_mem_valid_o),
    .out_o       (ex_mem_o),
    .out_ready_i (ex_mem_ready_i)
  );

  bpu_stats bpu_stats_inst (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .fire_i             (fire),
    .branch_i           (branch),
    .mispredict_i       (mispredict),
    .branch_count_o     (branch_count_o),
    .mispredict_count_o (mispredict_count_o)
  );

endmodule

// ==== dv/exu_stage_tb.sv ====
`timescale 1ns/1ps

module exu_stage_tb;

  localparam int TIMEOUT = 200;  // cycles allowed for any single wait

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      id_ex_valid_i;
  exu_pipe_pkg::id_ex_t      id_ex_i;
  logic                      id_ex_ready_o;
  logic                      ex_mem_valid_o;
  exu_pipe_pkg::ex_mem_t     ex_mem_o;
  logic                      ex_mem_ready_i;
  logic                      redirect_valid_o;
  exu_pipe_pkg::redirect_t   redirect_pc_o;
  logic                      bpu_update_valid_o;
  exu_pipe_pkg::bpu_update_t bpu_update_o;
  exu_isa_pkg::word_t        branch_count_o;
  exu_isa_pkg::word_t        mispredict_count_o;

  exu_pipe_pkg::ex_mem_t exp_q[$];  // results the stage still owes in order
  exu_pipe_pkg::ex_mem_t held;
  logic                  xfer_seen;
  logic                  stall_seen;
  int                    branch_total;
  int                    mispredict_total;

  exu_stage exu_stage_inst (.*);

  always #10 clk_i = ~clk_i;

  // downstream accepts roughly 70% of cycles
  task automatic drive_ready();
    forever begin
      @(posedge clk_i);
      ex_mem_ready_i <= (($urandom % 100) < 70);
    end
  endtask

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, want);
      abort_run();
    end
  endtask

  function automatic exu_isa_pkg::jump_type_e jump_type_of(input exu_isa_pkg::exc_op_e op);
    case (op)
      exu_isa_pkg::EXC_JAL:    return exu_isa_pkg::JT_JAL;
      exu_isa_pkg::EXC_JALR:   return exu_isa_pkg::JT_JALR;
      exu_isa_pkg::EXC_BRANCH: return exu_isa_pkg::JT_BRANCH;
      default:                 return exu_isa_pkg::JT_NONE;
    endcase
  endfunction

  // drive one instruction, hold it until accepted, check the transfer-cycle outputs
  task automatic issue(input exu_pipe_pkg::id_ex_t item, input logic [31:0] res,
                       input logic tkn, input logic rdr, input logic [31:0] rdr_pc);
    exu_pipe_pkg::ex_mem_t want;
    logic                  ctl;
    int                    waited;
    ctl    = (jump_type_of(item.exc_op) != exu_isa_pkg::JT_NONE);
    waited = 0;
    id_ex_valid_i <= 1'b1;
    id_ex_i       <= item;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout: id_ex_ready_o stayed low for %0d cycles", TIMEOUT);
        abort_run();
      end
      if (!id_ex_ready_o) begin
        check_val("redirect_valid_o", redirect_valid_o, 1'b0);  // no transfer, no redirect
        check_val("bpu_update_valid_o", bpu_update_valid_o, 1'b0);
      end
    end while (!id_ex_ready_o);
    check_val("redirect_valid_o", redirect_valid_o, rdr);
    if (rdr) check_val("redirect_pc_o", redirect_pc_o.pc, rdr_pc);
    check_val("bpu_update_valid_o", bpu_update_valid_o, ctl);
    if (ctl) begin
      check_val("bpu_update_o.pc", bpu_update_o.pc, item.pc);
      check_val("bpu_update_o.taken", bpu_update_o.taken, tkn);
      check_val("bpu_update_o.correct", bpu_update_o.correct, !rdr);
      check_val("bpu_update_o.jump_type", bpu_update_o.jump_type, jump_type_of(item.exc_op));
      check_val("bpu_update_o.which_pdt", bpu_update_o.which_pdt, item.which_pdt);
      check_val("bpu_update_o.history", bpu_update_o.history, item.history);
      branch_total++;
      mispredict_total += rdr;
    end
    want.pc         = item.pc;
    want.inst       = item.inst;
    want.rd         = item.rd;
    want.rs2_data   = item.rs2_data;
    want.alu_result = res;
    want.mem_op     = item.mem_op;
    want.exc_op     = item.exc_op;
    want.trap       = item.trap;
    exp_q.push_back(want);
    @(posedge clk_i);  // transfer edge
  endtask

  task automatic compare_output();
    exu_pipe_pkg::ex_mem_t want;
    if (exp_q.size() == 0) begin
      $display("Result on ex_mem_o at time %0t with nothing outstanding", $time);
      abort_run();
    end
    want = exp_q.pop_front();
    check_val("ex_mem_o.pc", ex_mem_o.pc, want.pc);
    check_val("ex_mem_o.inst", ex_mem_o.inst, want.inst);
    check_val("ex_mem_o.rd", ex_mem_o.rd, want.rd);
    check_val("ex_mem_o.rs2_data", ex_mem_o.rs2_data, want.rs2_data);
    check_val("ex_mem_o.alu_result", ex_mem_o.alu_result, want.alu_result);
    check_val("ex_mem_o.mem_op", ex_mem_o.mem_op, want.mem_op);
    check_val("ex_mem_o.exc_op", ex_mem_o.exc_op, want.exc_op);
    check_val("ex_mem_o.trap", ex_mem_o.trap, want.trap);
  endtask

  // output side is sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (xfer_seen) check_val("ex_mem_valid_o", ex_mem_valid_o, 1'b1);
      if (stall_seen) begin
        assert (ex_mem_o === held) else begin
          $display("Mismatch at time %0t: ex_mem_o got %h expected %h", $time, ex_mem_o, held);
          abort_run();
        end
      end
      if (ex_mem_valid_o && !ex_mem_ready_i) check_val("id_ex_ready_o", id_ex_ready_o, 1'b0);
      if (ex_mem_valid_o && ex_mem_ready_i) compare_output();
      xfer_seen  = id_ex_valid_i && id_ex_ready_o;
      stall_seen = ex_mem_valid_o && !ex_mem_ready_i;
      held       = ex_mem_o;
    end
  end

  initial begin
    int                   fd;
    int                   n;
    int                   seed;
    int                   waited;
    string                line;
    logic [31:0]          pc, rs1, rs2, imm;
    logic [31:0]          exc, alu, rd, pdt;
    logic [31:0]          res, tkn, rdr, rdr_pc;
    logic [31:0]          r;
    exu_pipe_pkg::id_ex_t item;
    seed             = $urandom(32'h484ec3dc);
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    id_ex_valid_i    = 1'b0;
    id_ex_i          = '0;
    ex_mem_ready_i   = 1'b0;
    xfer_seen        = 1'b0;
    stall_seen       = 1'b0;
    branch_total     = 0;
    mispredict_total = 0;
    fork
      drive_ready();
    join_none
    fd = $fopen("dv/exu_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file dv/exu_trace.txt");
      abort_run();
    end
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_val("ex_mem_valid_o", ex_mem_valid_o, 1'b0);
    check_val("redirect_valid_o", redirect_valid_o, 1'b0);
    check_val("bpu_update_valid_o", bpu_update_valid_o, 1'b0);
    check_val("branch_count_o", branch_count_o, 32'd0);
    check_val("mispredict_count_o", mispredict_count_o, 32'd0);
    @(posedge clk_i);
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                             pc, rs1, rs2, imm, exc, alu, rd, pdt, res, tkn, rdr, rdr_pc);
      if (n == 12) begin
        r              = $urandom;  // filler for the fields the stage only carries
        item.pc        = pc;
        item.inst      = $urandom;
        item.rd        = rd[4:0];
        item.rs1_data  = rs1;
        item.rs2_data  = rs2;
        item.imm       = imm;
        item.exc_op    = exu_isa_pkg::exc_op_e'(exc[3:0]);
        item.alu_op    = exu_isa_pkg::alu_op_e'(alu[3:0]);
        item.mem_op    = r[11:9];
        item.trap      = r[15:12];
        item.pdt_taken = pdt[0];
        item.which_pdt = r[8];
        item.history   = r[7:0];
        issue(item, res, tkn[0], rdr[0], rdr_pc);
      end
    end
    $fclose(fd);
    id_ex_valid_i <= 1'b0;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout: %0d results never left ex_mem_o", exp_q.size());
        abort_run();
      end
    end
    @(negedge clk_i);
    check_val("ex_mem_valid_o", ex_mem_valid_o, 1'b0);  // drained with nothing behind it
    check_val("branch_count_o", branch_count_o, branch_total);
    check_val("mispredict_count_o", mispredict_count_o, mispredict_total);
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== dv/exu_trace.txt ====
# pc rs1 rs2 imm exc_op alu_op rd pdt_taken : alu_result taken redirect redirect_pc, all hex
# exc_op 1 lui 2 auipc 3 jal 4 jalr 5 load 6 store 7 branch 8 opimm 9 opreg
00001000 00000005 00000007 00000000 9 0 01 0 0000000c 0 0 00000000
00001004 00000003 00000005 00000000 9 1 02 0 fffffffe 0 0 00000000
00001008 00000001 00000024 00000000 9 2 03 0 00000010 0 0 00000000
0000100c ffffffff 00000001 00000000 9 3 04 0 00000001 0 0 00000000
00001010 ffffffff 00000001 00000000 9 4 05 0 00000000 0 0 00000000
00001014 ff00ff00 0f0f0f0f 00000000 9 5 06 0 f00ff00f 0 0 00000000
00001018 80000000 00000004 00000000 9 6 07 0 08000000 0 0 00000000
0000101c 80000000 00000004 00000000 9 7 08 0 f8000000 0 0 00000000
00001020 000000f0 0000000f 00000000 9 8 09 0 000000ff 0 0 00000000
00001024 12345678 0000ffff 00000000 9 9 0a 0 00005678 0 0 00000000
00001028 00000100 deadbeef fffffff0 8 0 0b 0 000000f0 0 0 00000000
0000102c 20000000 00000000 00000008 5 0 0c 0 20000008 0 0 00000000
00001030 20000000 cafef00d fffffffc 6 0 00 0 1ffffffc 0 0 00000000
00001034 11111111 00000000 12345abc 1 0 0d 0 12345000 0 0 00000000
00001038 00000000 00000000 00001fff 2 0 0e 0 00002038 0 0 00000000
0000103c 00000000 00000000 00000100 3 0 01 0 00001040 1 1 0000113c
00002000 00000000 00000000 fffffff0 3 0 01 1 00002004 1 0 00000000
00002004 00003000 00000000 00000010 4 0 01 0 00002008 1 1 00003010
00002008 00004000 00000000 00000004 4 0 01 1 0000200c 1 0 00000000
00003000 00000005 00000005 00000040 7 a 00 0 00000001 1 1 00003040
00003004 00000005 00000005 00000040 7 b 00 1 00000000 0 1 00003008
00003008 fffffffe 00000001 ffffff00 7 c 00 1 00000001 1 0 00000000
0000300c fffffffe 00000001 00000020 7 d 00 0 00000000 0 0 00000000
00003010 fffffffe 00000001 00000020 7 e 00 1 00000000 0 1 00003014
00003014 fffffffe 00000001 ffffffe0 7 f 00 0 00000001 1 1 00002ff4
00003018 00000001 00000002 00000010 7 a 00 0 00000000 0 0 00000000

// ==== sim.f ====
+incdir+include
hw/exu_isa_pkg.sv
hw/exu_pipe_pkg.sv
hw/alu.sv
hw/exu.sv
hw/ex_mem_reg.sv
hw/bpu_stats.sv
hw/exu_stage.sv
dv/exu_stage_tb.sv
